/* Bender.yml */
package:
  name: scope_display

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/video_pkg.sv
      - source/sample_pkg.sv
      - source/vga_timing.sv
      - source/sample_ram.sv
      - source/sample_fetch.sv
      - source/trace_render.sv
      - source/scope_display.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_scope_display.sv

/* scope_display.f */
+incdir+source
source/video_pkg.sv
source/sample_pkg.sv
source/vga_timing.sv
source/sample_ram.sv
source/sample_fetch.sv
source/trace_render.sv
source/scope_display.sv
tb/tb_scope_display.sv

/* source/sample_fetch.sv */
// column fetch and magnitude pipeline
`timescale 1ns/10ps
`include "scope_params.svh"

module sample_fetch (
	input  logic                              clk,
	input  logic                              i_rst_n,
	// scan position from timing
	input  logic [`SCOPE_COORD_W-1:0]         i_x,
	input  logic [`SCOPE_COORD_W-1:0]         i_y,
	input  logic                              i_blank,
	input  logic                              i_hs,
	input  logic                              i_vs,
	input  logic [3:0]                        i_zoom,     // static level
	// buffer read
	input  logic signed [`SCOPE_SAMPLE_W-1:0] i_rd_data,
	output logic [`SCOPE_ADDR_W-1:0]          o_rd_addr,
	// to render, 2 cycles behind the counters
	output logic [`SCOPE_MAG_W-1:0]           o_mag,
	output logic [`SCOPE_COORD_W-1:0]         o_y,
	output logic                              o_blank,
	output logic                              o_hs,
	output logic                              o_vs
);

	logic [3:0]                zoom_c;      // clamped 4..10
	logic [3:0]                shift_amt;   // 0..6
	logic [`SCOPE_COORD_W-1:0] col_idx;
	logic [`SCOPE_MAG_W-1:0]   mag_q;
	logic [`SCOPE_COORD_W-1:0] y_d1, y_d2;
	logic                      blank_d1, blank_d2;
	logic                      hs_d1, hs_d2;
	logic                      vs_d1, vs_d2;

	assign zoom_c    = sample_pkg::clamp_zoom(i_zoom);
	assign shift_amt = 4'd10 - zoom_c;
	assign col_idx   = i_x >> shift_amt;  // zoom 10 maps 1:1, zoom 4 gives 64 wide steps

	// right of the visible area park on entry 0
	assign o_rd_addr = (i_x < `SCOPE_H_ACTIVE) ? col_idx[`SCOPE_ADDR_W-1:0] : '0;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mag_q    <= '0;
			y_d1     <= '0;
			y_d2     <= '0;
			blank_d1 <= 1'b1;  // blank until the pipe fills
			blank_d2 <= 1'b1;
			hs_d1    <= 1'b1;
			hs_d2    <= 1'b1;
			vs_d1    <= 1'b1;
			vs_d2    <= 1'b1;
		end else begin
			// stage 1 lines up with the ram output
			y_d1     <= i_y;
			blank_d1 <= i_blank;
			hs_d1    <= i_hs;
			vs_d1    <= i_vs;
			// stage 2 lines up with the magnitude
			y_d2     <= y_d1;
			blank_d2 <= blank_d1;
			hs_d2    <= hs_d1;
			vs_d2    <= vs_d1;
			mag_q    <= blank_d1 ? '0 : sample_pkg::rectify_sat(i_rd_data);
		end
	end

	assign o_mag   = mag_q;
	assign o_y     = y_d2;
	assign o_blank = blank_d2;
	assign o_hs    = hs_d2;
	assign o_vs    = vs_d2;

endmodule

/* source/sample_pkg.sv */
// sample arithmetic helpers
`include "scope_params.svh"

package sample_pkg;

	// abs value, clipped to the magnitude range
	function automatic logic [`SCOPE_MAG_W-1:0] rectify_sat(
		input logic signed [`SCOPE_SAMPLE_W-1:0] s
	);
		logic [`SCOPE_SAMPLE_W-1:0] a;
		a = s[`SCOPE_SAMPLE_W-1] ? -s : s;  // most negative wraps to 2^23, still saturates
		if (a > {`SCOPE_MAG_W{1'b1}})
			return {`SCOPE_MAG_W{1'b1}};  // 131071
		return a[`SCOPE_MAG_W-1:0];
	endfunction

	// keep zoom within 4..10
	function automatic logic [3:0] clamp_zoom(input logic [3:0] z);
		if (z < `SCOPE_ZOOM_MIN)
			return 4'(`SCOPE_ZOOM_MIN);
		if (z > `SCOPE_ZOOM_MAX)
			return 4'(`SCOPE_ZOOM_MAX);
		return z;
	endfunction

	// mag * 479 / 2^17, lands in 0..478
	function automatic logic [`SCOPE_COORD_W-1:0] bar_height(
		input logic [`SCOPE_MAG_W-1:0] mag
	);
		logic [`SCOPE_MAG_W+8:0] prod;  // 17 + 9 bits
		prod = mag * (`SCOPE_MAG_W+9)'(`SCOPE_V_ACTIVE - 1);
		return `SCOPE_COORD_W'(prod >> `SCOPE_MAG_W);
	endfunction

endpackage

/* source/sample_ram.sv */
// sample buffer, 1024 x 24
`timescale 1ns/10ps
`include "scope_params.svh"

module sample_ram (
	input  logic                             clk,
	// host write port
	input  logic                             i_wr_en,    // one cycle strobe
	input  logic [`SCOPE_ADDR_W-1:0]         i_wr_addr,
	input  logic signed [`SCOPE_SAMPLE_W-1:0] i_wr_data,
	// display read port
	input  logic [`SCOPE_ADDR_W-1:0]         i_rd_addr,
	output logic signed [`SCOPE_SAMPLE_W-1:0] o_rd_data  // 1 cycle after address
);

	localparam int DEPTH = 1 << `SCOPE_ADDR_W;

	logic signed [`SCOPE_SAMPLE_W-1:0] mem [DEPTH];  // contents start unknown
	logic signed [`SCOPE_SAMPLE_W-1:0] rd_q;

	// write side
	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// registered read, block ram style
	// a write shows up for a read issued the cycle after
	always_ff @(posedge clk) begin
		rd_q <= mem[i_rd_addr];
	end

	assign o_rd_data = rd_q;

endmodule

/* source/scope_display.sv */
// vga waveform viewer top
`timescale 1ns/10ps
`include "scope_params.svh"

module scope_display (
	input  logic                              clk,        // pixel clock
	input  logic                              i_rst_n,
	// host side
	input  logic                              i_wr_en,
	input  logic [`SCOPE_ADDR_W-1:0]          i_wr_addr,
	input  logic signed [`SCOPE_SAMPLE_W-1:0] i_wr_data,
	input  logic [3:0]                        i_zoom,
	// video side
	output logic                              o_hs,
	output logic                              o_vs,
	output logic [3:0]                        o_r,
	output logic [3:0]                        o_g,
	output logic [3:0]                        o_b
);

	// scan position, cycle 0
	logic [`SCOPE_COORD_W-1:0]         scan_x;
	logic [`SCOPE_COORD_W-1:0]         scan_y;
	logic                              scan_hs, scan_vs, scan_blank;
	// buffer read
	logic [`SCOPE_ADDR_W-1:0]          rd_addr;
	logic signed [`SCOPE_SAMPLE_W-1:0] rd_data;
	// cycle 2, into render
	logic [`SCOPE_MAG_W-1:0]           mag;
	logic [`SCOPE_COORD_W-1:0]         mag_y;
	logic                              mag_blank, mag_hs, mag_vs;

	vga_timing u_vga_timing (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.o_x     (scan_x),
		.o_y     (scan_y),
		.o_hs    (scan_hs),
		.o_vs    (scan_vs),
		.o_blank (scan_blank)
	);

	sample_ram u_sample_ram (
		.clk       (clk),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	sample_fetch u_sample_fetch (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_x       (scan_x),
		.i_y       (scan_y),
		.i_blank   (scan_blank),
		.i_hs      (scan_hs),
		.i_vs      (scan_vs),
		.i_zoom    (i_zoom),
		.i_rd_data (rd_data),
		.o_rd_addr (rd_addr),
		.o_mag     (mag),
		.o_y       (mag_y),
		.o_blank   (mag_blank),
		.o_hs      (mag_hs),
		.o_vs      (mag_vs)
	);

	trace_render u_trace_render (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_mag   (mag),
		.i_y     (mag_y),
		.i_blank (mag_blank),
		.i_hs    (mag_hs),
		.i_vs    (mag_vs),
		.o_r     (o_r),
		.o_g     (o_g),
		.o_b     (o_b),
		.o_hs    (o_hs),
		.o_vs    (o_vs)
	);

endmodule

/* source/scope_params.svh */
// scope display parameters
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

// horizontal scan, pixels per line
`define SCOPE_H_ACTIVE 640
`define SCOPE_H_FRONT  16
`define SCOPE_H_SYNC   96
`define SCOPE_H_TOTAL  800  // incl back porch of 48

// vertical scan, lines per frame
`define SCOPE_V_ACTIVE 480
`define SCOPE_V_FRONT  10
`define SCOPE_V_SYNC   2
`define SCOPE_V_TOTAL  525  // incl back porch of 33

// x and y counter width
`define SCOPE_COORD_W  11

// sample path
`define SCOPE_SAMPLE_W 24   // signed host samples
`define SCOPE_MAG_W    17   // magnitude, saturates at all ones
`define SCOPE_ADDR_W   10   // 1024 entry buffer

// zoom limits, shift = 10 - zoom
`define SCOPE_ZOOM_MIN 4
`define SCOPE_ZOOM_MAX 10

`endif

/* source/trace_render.sv */
// bar renderer and colour output
`timescale 1ns/10ps
`include "scope_params.svh"

module trace_render (
	input  logic                      clk,
	input  logic                      i_rst_n,
	input  logic [`SCOPE_MAG_W-1:0]   i_mag,    // rectified sample for this column
	input  logic [`SCOPE_COORD_W-1:0] i_y,
	input  logic                      i_blank,
	input  logic                      i_hs,
	input  logic                      i_vs,
	output logic [3:0]                o_r,
	output logic [3:0]                o_g,
	output logic [3:0]                o_b,
	output logic                      o_hs,     // active low
	output logic                      o_vs      // active low
);

	localparam logic [`SCOPE_COORD_W-1:0] BOTTOM = `SCOPE_V_ACTIVE - 1;  // line 479

	logic [`SCOPE_COORD_W-1:0] height;  // 0..478
	logic [`SCOPE_COORD_W-1:0] bar_top; // last unpainted line
	logic                      paint;
	logic [3:0]                r_nxt;
	logic [3:0]                r_q;
	logic                      hs_q, vs_q;

	assign height  = sample_pkg::bar_height(i_mag);
	assign bar_top = BOTTOM - height;  // never below 1

	// bar grows up from the bottom edge
	assign paint = !i_blank && (i_y > bar_top);

	// red bar on black
	always_comb begin
		r_nxt = 4'h0;
		if (paint) begin
			r_nxt = 4'hF;
		end
	end

	// colour and syncs leave together
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_q  <= 4'h0;
			hs_q <= 1'b1;
			vs_q <= 1'b1;
		end else begin
			r_q  <= r_nxt;
			hs_q <= i_hs;
			vs_q <= i_vs;
		end
	end

	assign o_r  = r_q;
	assign o_g  = 4'h0;  // bar is pure red
	assign o_b  = 4'h0;
	assign o_hs = hs_q;
	assign o_vs = vs_q;

endmodule

/* source/vga_timing.sv */
// vga scan timing generator
`timescale 1ns/10ps
`include "scope_params.svh"

module vga_timing (
	input  logic                      clk,
	input  logic                      i_rst_n,
	output logic [`SCOPE_COORD_W-1:0] o_x,     // pixel in line
	output logic [`SCOPE_COORD_W-1:0] o_y,     // line in frame
	output logic                      o_hs,    // active low
	output logic                      o_vs,    // active low
	output logic                      o_blank  // high outside 640x480
);

	logic [`SCOPE_COORD_W-1:0] x_cnt;
	logic [`SCOPE_COORD_W-1:0] y_cnt;
	logic [`SCOPE_COORD_W-1:0] x_nxt;
	logic [`SCOPE_COORD_W-1:0] y_nxt;
	logic                      line_end;
	logic                      frame_end;
	logic                      hs_q;
	logic                      vs_q;
	logic                      blank_q;

	assign line_end  = (x_cnt == `SCOPE_H_TOTAL - 1);  // pixel 799
	assign frame_end = (y_cnt == `SCOPE_V_TOTAL - 1);  // line 524

	// next position, y steps only at end of line
	always_comb begin
		x_nxt = x_cnt + 1'b1;
		y_nxt = y_cnt;
		if (line_end) begin
			x_nxt = '0;
			if (frame_end)
				y_nxt = '0;
			else
				y_nxt = y_cnt + 1'b1;
		end
	end

	// syncs decoded from the next count so they land with it
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			x_cnt   <= '0;
			y_cnt   <= '0;
			hs_q    <= 1'b1;  // inactive
			vs_q    <= 1'b1;
			blank_q <= 1'b1;
		end else begin
			x_cnt   <= x_nxt;
			y_cnt   <= y_nxt;
			hs_q    <= ~video_pkg::hsync_window(x_nxt);
			vs_q    <= ~video_pkg::vsync_window(y_nxt);
			blank_q <= ~video_pkg::is_active(x_nxt, y_nxt);
		end
	end

	assign o_x     = x_cnt;
	assign o_y     = y_cnt;
	assign o_hs    = hs_q;
	assign o_vs    = vs_q;
	assign o_blank = blank_q;

endmodule

/* source/video_pkg.sv */
// scan geometry helpers
`include "scope_params.svh"

package video_pkg;

	// hsync low from pixel 656 through 751
	function automatic logic hsync_window(input logic [`SCOPE_COORD_W-1:0] x);
		logic [`SCOPE_COORD_W-1:0] sta;
		logic [`SCOPE_COORD_W-1:0] fin;
		sta = `SCOPE_H_ACTIVE + `SCOPE_H_FRONT;
		fin = `SCOPE_H_ACTIVE + `SCOPE_H_FRONT + `SCOPE_H_SYNC;  // first pixel past sync
		return (x >= sta) && (x < fin);
	endfunction

	// vsync low on lines 490 and 491
	function automatic logic vsync_window(input logic [`SCOPE_COORD_W-1:0] y);
		logic [`SCOPE_COORD_W-1:0] sta;
		logic [`SCOPE_COORD_W-1:0] fin;
		sta = `SCOPE_V_ACTIVE + `SCOPE_V_FRONT;
		fin = `SCOPE_V_ACTIVE + `SCOPE_V_FRONT + `SCOPE_V_SYNC;
		return (y >= sta) && (y < fin);
	endfunction

	// visible pixel, anything else is blanking
	function automatic logic is_active(
		input logic [`SCOPE_COORD_W-1:0] x,
		input logic [`SCOPE_COORD_W-1:0] y
	);
		return (x < `SCOPE_H_ACTIVE) && (y < `SCOPE_V_ACTIVE);
	endfunction

endpackage

/* tb/tb_scope_display.sv */
// scope display testbench
`timescale 1ns/10ps
`include "scope_params.svh"

module tb_scope_display;

	localparam int NT       = 6;   // table entries
	localparam int NW       = 4;   // writes per entry
	localparam int NP       = 6;   // probes per entry
	localparam int FRAME    = `SCOPE_H_TOTAL * `SCOPE_V_TOTAL;  // 420000 cycles
	localparam int LATENCY  = 3;   // counters to pins
	localparam int WAIT_MAX = 2 * FRAME;
	localparam int DEPTH    = 1 << `SCOPE_ADDR_W;
	localparam int HS_START = `SCOPE_H_ACTIVE + `SCOPE_H_FRONT;  // 656
	localparam int VS_START = `SCOPE_V_ACTIVE + `SCOPE_V_FRONT;  // 490

	logic                              clk;
	logic                              i_rst_n;
	logic                              i_wr_en;
	logic [`SCOPE_ADDR_W-1:0]          i_wr_addr;
	logic signed [`SCOPE_SAMPLE_W-1:0] i_wr_data;
	logic [3:0]                        i_zoom;
	logic                              o_hs;
	logic                              o_vs;
	logic [3:0]                        o_r, o_g, o_b;

	// stimulus table, expected colour filled in once the writes are known
	logic [3:0]                        t_zoom [NT];
	int                                t_nwr  [NT];
	logic [`SCOPE_ADDR_W-1:0]          t_wa   [NT][NW];
	logic signed [`SCOPE_SAMPLE_W-1:0] t_wd   [NT][NW];
	int                                t_px   [NT][NP];
	int                                t_py   [NT][NP];
	logic                              t_red  [NT][NP];

	logic signed [`SCOPE_SAMPLE_W-1:0] shadow [DEPTH];  // host copy of the buffer
	logic [31:0] lfsr;
	int          cyc;        // posedges since reset release
	logic        running;
	int          out_x;      // pixel on the outputs
	int          out_y;
	int          scan_y;     // line held by the counters
	int          errors;
	int          checks;
	logic        timed_out;

	scope_display i_scope_display (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.i_zoom    (i_zoom),
		.o_hs      (o_hs),
		.o_vs      (o_vs),
		.o_r       (o_r),
		.o_g       (o_g),
		.o_b       (o_b)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 50 MHz stand-in for the pixel clock
	end

	always @(posedge clk) begin
		if (running)
			cyc <= cyc + 1;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// 8 random bits above the address, so every entry differs
	function automatic logic signed [`SCOPE_SAMPLE_W-1:0] fill_sample(input int a);
		logic signed [17:0] v;
		v = 18'(a);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			v[10+i] = lfsr[0];
		end
		return v;  // sign extends to 24 bits
	endfunction

	// red or black for a pixel, from the shadow buffer
	function automatic logic expect_red(input logic [3:0] zoom, input int x, input int y);
		logic [3:0]              cz;
		int                      addr;
		logic [`SCOPE_MAG_W-1:0] mag;
		int                      h;
		if (x >= `SCOPE_H_ACTIVE || y >= `SCOPE_V_ACTIVE)
			return 1'b0;
		cz   = sample_pkg::clamp_zoom(zoom);
		addr = x >> (10 - cz);
		mag  = sample_pkg::rectify_sat(shadow[addr]);
		h    = sample_pkg::bar_height(mag);
		return y > (`SCOPE_V_ACTIVE - 1) - h;
	endfunction

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s at pixel (%0d,%0d), got %0h expected %0h",
				$time, what, out_x, out_y, got, exp);
		end
	endtask

	// one clock, then refresh the position model
	task automatic step_cycle();
		int pos;
		@(negedge clk);
		pos = cyc - LATENCY;
		if (pos < 0)
			pos = 0;
		out_x  = pos % `SCOPE_H_TOTAL;
		out_y  = (pos / `SCOPE_H_TOTAL) % `SCOPE_V_TOTAL;
		scan_y = (cyc / `SCOPE_H_TOTAL) % `SCOPE_V_TOTAL;
	endtask

	task automatic check_idle();
		check_val(o_hs, 1, "hsync while idle");
		check_val(o_vs, 1, "vsync while idle");
		check_val({o_r, o_g, o_b}, 0, "colour while idle");
	endtask

	task automatic host_write(input logic [`SCOPE_ADDR_W-1:0] a,
			input logic signed [`SCOPE_SAMPLE_W-1:0] d);
		i_wr_en   = 1'b1;
		i_wr_addr = a;
		i_wr_data = d;
		shadow[a] = d;
		step_cycle();
		i_wr_en   = 1'b0;
	endtask

	// counters on lines 480..499, leaves room before the wrap
	task automatic wait_vblank();
		int n;
		n = 0;
		while (!timed_out && !(scan_y >= `SCOPE_V_ACTIVE && scan_y < `SCOPE_V_ACTIVE + 20)) begin
			step_cycle();
			n++;
			if (n > WAIT_MAX) begin
				$display("timeout: the scan never reached vertical blanking");
				errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	// outputs showing pixel (0,0)
	task automatic wait_frame_start();
		int n;
		n = 0;
		while (!timed_out && !(cyc >= LATENCY && out_x == 0 && out_y == 0)) begin
			step_cycle();
			n++;
			if (n > WAIT_MAX) begin
				$display("timeout: the outputs never reached the start of a frame");
				errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic check_frame(input int e);
		int   hs_low;
		int   vs_low;
		logic blank;
		hs_low = 0;
		vs_low = 0;
		for (int c = 0; c < FRAME; c++) begin
			blank = (out_x >= `SCOPE_H_ACTIVE) || (out_y >= `SCOPE_V_ACTIVE);
			check_val(o_hs, (out_x >= HS_START && out_x < HS_START + `SCOPE_H_SYNC) ? 0 : 1,
				"hsync");
			check_val(o_vs, (out_y >= VS_START && out_y < VS_START + `SCOPE_V_SYNC) ? 0 : 1,
				"vsync");
			if (!o_hs)
				hs_low++;
			if (!o_vs)
				vs_low++;
			if (blank)
				check_val({o_r, o_g, o_b}, 0, "colour in blanking");
			for (int p = 0; p < NP; p++) begin
				if (out_x == t_px[e][p] && out_y == t_py[e][p])
					check_val({o_r, o_g, o_b}, t_red[e][p] ? 12'hF00 : 12'h000, "probe colour");
			end
			step_cycle();
		end
		check_val(hs_low, `SCOPE_H_SYNC * `SCOPE_V_TOTAL, "hsync low cycles per frame");
		check_val(vs_low, `SCOPE_V_SYNC * `SCOPE_H_TOTAL, "vsync low cycles per frame");
	endtask

	task automatic build_table();
		t_zoom = '{4'd10, 4'd0, 4'd4, 4'd7, 4'd15, 4'd10};  // 0 and 15 test the clamp
		t_nwr  = '{4, 1, 0, 1, 1, 4};
		// signs, zero and saturation at zoom 10
		t_wa[0] = '{100, 200, 300, 400};
		t_wd[0] = '{24'sd65536, -24'sd98304, 24'sd0, 24'sd4000000};
		t_px[0] = '{100, 100, 200, 300, 400, 400};
		t_py[0] = '{241, 240, 121, 479, 2, 1};
		// zoom 0 acts as 4, most negative sample
		t_wa[1] = '{2, 0, 0, 0};
		t_wd[1] = '{-24'sd8388608, 24'sd0, 24'sd0, 24'sd0};
		t_px[1] = '{5, 130, 130, 639, 64, 700};
		t_py[1] = '{479, 1, 2, 479, 300, 479};
		// zoom 4, 64 pixel columns on the filler
		t_wa[2] = '{0, 0, 0, 0};
		t_wd[2] = '{24'sd0, 24'sd0, 24'sd0, 24'sd0};
		t_px[2] = '{63, 64, 320, 575, 639, 10};
		t_py[2] = '{479, 479, 400, 479, 240, 470};
		// zoom 7, exact full scale
		t_wa[3] = '{79, 0, 0, 0};
		t_wd[3] = '{24'sd131071, 24'sd0, 24'sd0, 24'sd0};
		t_px[3] = '{632, 632, 100, 8, 7, 639};
		t_py[3] = '{2, 1, 479, 470, 470, 300};
		// zoom 15 acts as 10
		t_wa[4] = '{511, 0, 0, 0};
		t_wd[4] = '{-24'sd131072, 24'sd0, 24'sd0, 24'sd0};
		t_px[4] = '{511, 511, 510, 639, 0, 1};
		t_py[4] = '{2, 1, 479, 479, 479, 460};
		// full scale everywhere the blanking reads
		t_wa[5] = '{0, 639, 320, 1};
		t_wd[5] = '{24'sd8388607, 24'sd8388607, -24'sd8388608, 24'sd8388607};
		t_px[5] = '{640, 799, 320, 639, 0, 320};
		t_py[5] = '{479, 479, 480, 524, 479, 479};
	endtask

	initial begin
		i_rst_n   = 1'b0;
		i_wr_en   = 1'b0;
		i_wr_addr = '0;
		i_wr_data = '0;
		i_zoom    = 4'd10;
		cyc       = 0;
		running   = 1'b0;
		out_x     = 0;
		out_y     = 0;
		scan_y    = 0;
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		lfsr      = 32'hda52_7432;
		build_table();

		// reset for 3 cycles, then 3 more while the pipe fills
		for (int k = 0; k < 3; k++) begin
			step_cycle();
			check_idle();
		end
		i_rst_n = 1'b1;
		running = 1'b1;
		for (int k = 0; k < LATENCY; k++) begin
			check_idle();
			step_cycle();
		end

		// whole buffer gets known contents first
		wait_vblank();
		for (int a = 0; a < DEPTH && !timed_out; a++)
			host_write(a, fill_sample(a));

		for (int e = 0; e < NT && !timed_out; e++) begin
			wait_vblank();
			i_zoom = t_zoom[e];
			for (int w = 0; w < t_nwr[e] && !timed_out; w++)
				host_write(t_wa[e][w], t_wd[e][w]);
			for (int p = 0; p < NP; p++)
				t_red[e][p] = expect_red(t_zoom[e], t_px[e][p], t_py[e][p]);
			wait_frame_start();
			if (!timed_out)
				check_frame(e);
		end

		$display("tb_scope_display: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
